//--- Bender.yml
package:
  name: sdram_bank

sources:
  - src/sdram_bank_pkg.sv
  - src/slot_cache.sv
  - src/burst_counter.sv
  - src/bank_arbiter.sv
  - src/sdram_bank.sv
  - target: simulation
    files:
      - verif/sdram_bank_assertions.sv
      - verif/sdram_bank_tb.sv

//--- src/bank_arbiter.sv
// ========================================
// Bank arbiter
// Fixed priority FSM granting one slot at
// a time and driving the SDRAM request
// ========================================
`timescale 1ns/1ns
`default_nettype none

module bank_arbiter (
    input  logic                               clk,
    input  logic                               arst_n,
    input  sdram_bank_pkg::bank_req_t          reqs [sdram_bank_pkg::NSLOTS],
    input  logic                               ack,
    input  sdram_bank_pkg::bank_rsp_t          rsp,
    output logic [sdram_bank_pkg::NSLOTS-1:0]  grant,
    output logic                               busy_rd,
    output sdram_bank_pkg::bank_addr_t         ba_addr,
    output logic                               ba_rd,
    output logic                               ba_wr,
    output logic [15:0]                        ba_din,
    output logic [1:0]                         ba_din_m
);
    import sdram_bank_pkg::*;

    arb_state_t state;
    slot_id_t   sel;        // Slot owning the bank
    slot_id_t   pick;
    logic       pick_vld;
    bank_req_t  cur;        // Latched request

    // Scan downwards so the lowest index wins
    always_comb begin
        pick     = SLOT_RAM;
        pick_vld = 1'b0;
        for (int i = NSLOTS - 1; i >= 0; i--) begin
            if (reqs[i].pending) begin
                pick     = slot_id_t'(i);
                pick_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            sel   <= SLOT_RAM;
        end else begin
            case (state)
                IDLE: begin
                    if (pick_vld) begin
                        state <= REQ;
                        sel   <= pick;
                    end
                end
                REQ:     if (ack) state <= WAIT;
                WAIT:    if (rsp.done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && pick_vld) cur <= reqs[pick];
    end

    always_comb begin
        grant = '0;
        if (state != IDLE) grant[sel] = 1'b1;
    end

    // Levels held until ack
    assign ba_rd    = (state == REQ) && !cur.we;
    assign ba_wr    = (state == REQ) && cur.we;
    assign busy_rd  = (state != IDLE) && !cur.we;
    assign ba_addr  = cur.addr;
    assign ba_din   = cur.din;
    assign ba_din_m = cur.mask;

endmodule

`default_nettype wire

//--- src/burst_counter.sv
// ========================================
// Burst collector
// Packs the two read words into one
// 32-bit response and flags completion
// ========================================
`timescale 1ns/1ns
`default_nettype none

module burst_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      dst,
    input  logic                      rdy,
    input  logic [15:0]               data_read,
    input  logic                      busy_rd,
    output sdram_bank_pkg::bank_rsp_t rsp
);
    logic        wcnt;      // Next half to fill
    logic        done_q;
    logic [31:0] data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wcnt   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= rdy;                  // Write bursts end here too
            if (rdy) wcnt <= 1'b0;
            else if (dst) wcnt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (busy_rd && (dst || rdy)) begin
            if (wcnt) data_q[31:16] <= data_read;
            else data_q[15:0] <= data_read;
        end
    end

    assign rsp = '{done: done_q, data: data_q};

endmodule

`default_nettype wire

//--- src/sdram_bank.sv
// ========================================
// SDRAM bank front end, top level
// Four cached slots sharing one bank
// ========================================
`timescale 1ns/1ns
`default_nettype none

module sdram_bank (
    input  logic                       clk,
    input  logic                       arst_n,
    // Main CPU work RAM
    input  logic                       ram_cs,
    input  logic [16:0]                ram_addr,
    input  logic                       ram_rnw,
    input  logic [15:0]                ram_din,
    input  logic [1:0]                 ram_dsn,
    output logic                       ram_ok,
    output logic [15:0]                ram_data,
    // Main CPU ROM
    input  logic                       rom_cs,
    input  logic [19:0]                rom_addr,
    output logic                       rom_ok,
    output logic [15:0]                rom_data,
    // Sound CPU ROM
    input  logic                       snd_cs,
    input  logic [15:0]                snd_addr,
    output logic                       snd_ok,
    output logic [7:0]                 snd_data,
    // Graphics ROM
    input  logic                       gfx_cs,
    input  logic [19:0]                gfx_addr,
    output logic                       gfx_ok,
    output logic [31:0]                gfx_data,
    // SDRAM bank port
    output sdram_bank_pkg::bank_addr_t ba_addr,
    output logic                       ba_rd,
    output logic                       ba_wr,
    output logic [15:0]                ba_din,
    output logic [1:0]                 ba_din_m,
    input  logic                       ba_ack,
    input  logic                       ba_dst,
    input  logic                       ba_rdy,
    input  logic [15:0]                data_read
);
    import sdram_bank_pkg::*;

    bank_req_t         reqs [NSLOTS];
    bank_rsp_t         rsp;
    logic [NSLOTS-1:0] grant;
    logic              busy_rd;

    slot_cache #(.data_t(logic [15:0]), .SLOT(SLOT_RAM)) u_ram (
        .clk    ( clk                ),
        .arst_n ( arst_n             ),
        .cs     ( ram_cs             ),
        .addr   ( {6'd0, ram_addr}   ),
        .we     ( !ram_rnw           ),
        .din    ( ram_din            ),
        .mask   ( ram_dsn            ),
        .grant  ( grant[SLOT_RAM]    ),
        .rsp    ( rsp                ),
        .req    ( reqs[SLOT_RAM]     ),
        .ok     ( ram_ok             ),
        .dout   ( ram_data           )
    );

    slot_cache #(.data_t(logic [15:0]), .SLOT(SLOT_ROM)) u_rom (
        .clk    ( clk                ),
        .arst_n ( arst_n             ),
        .cs     ( rom_cs             ),
        .addr   ( {3'd0, rom_addr}   ),
        .we     ( 1'b0               ),     // Read only
        .din    ( 16'd0              ),
        .mask   ( 2'b11              ),
        .grant  ( grant[SLOT_ROM]    ),
        .rsp    ( rsp                ),
        .req    ( reqs[SLOT_ROM]     ),
        .ok     ( rom_ok             ),
        .dout   ( rom_data           )
    );

    slot_cache #(.data_t(logic [7:0]), .SLOT(SLOT_SND)) u_snd (
        .clk    ( clk                ),
        .arst_n ( arst_n             ),
        .cs     ( snd_cs             ),
        .addr   ( {7'd0, snd_addr}   ),
        .we     ( 1'b0               ),
        .din    ( 16'd0              ),
        .mask   ( 2'b11              ),
        .grant  ( grant[SLOT_SND]    ),
        .rsp    ( rsp                ),
        .req    ( reqs[SLOT_SND]     ),
        .ok     ( snd_ok             ),
        .dout   ( snd_data           )
    );

    slot_cache #(.data_t(logic [31:0]), .SLOT(SLOT_GFX)) u_gfx (
        .clk    ( clk                ),
        .arst_n ( arst_n             ),
        .cs     ( gfx_cs             ),
        .addr   ( {3'd0, gfx_addr}   ),
        .we     ( 1'b0               ),
        .din    ( 16'd0              ),
        .mask   ( 2'b11              ),
        .grant  ( grant[SLOT_GFX]    ),
        .rsp    ( rsp                ),
        .req    ( reqs[SLOT_GFX]     ),
        .ok     ( gfx_ok             ),
        .dout   ( gfx_data           )
    );

    bank_arbiter u_arb (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .reqs     ( reqs     ),
        .ack      ( ba_ack   ),
        .rsp      ( rsp      ),
        .grant    ( grant    ),
        .busy_rd  ( busy_rd  ),
        .ba_addr  ( ba_addr  ),
        .ba_rd    ( ba_rd    ),
        .ba_wr    ( ba_wr    ),
        .ba_din   ( ba_din   ),
        .ba_din_m ( ba_din_m )
    );

    burst_counter u_burst (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .dst       ( ba_dst    ),
        .rdy       ( ba_rdy    ),
        .data_read ( data_read ),
        .busy_rd   ( busy_rd   ),
        .rsp       ( rsp       )
    );

endmodule

`default_nettype wire

//--- src/sdram_bank_pkg.sv
// ========================================
// SDRAM bank front end
// Shared types, slot offsets and the
// request and response records
// ========================================
`default_nettype none

package sdram_bank_pkg;

    typedef logic [22:0] bank_addr_t;   // Word address inside the bank

    localparam int NSLOTS = 4;

    typedef logic [1:0] slot_id_t;

    // Priority order, lowest index wins
    localparam slot_id_t SLOT_RAM = 2'd0;
    localparam slot_id_t SLOT_ROM = 2'd1;
    localparam slot_id_t SLOT_SND = 2'd2;
    localparam slot_id_t SLOT_GFX = 2'd3;

    localparam bank_addr_t SLOT_OFFSET [NSLOTS] = '{
        23'h30_0000,    // Work RAM
        23'h00_0000,    // Main CPU ROM
        23'h38_0000,    // Sound CPU ROM
        23'h10_0000     // Graphics ROM
    };

    typedef struct packed {
        logic        pending;
        bank_addr_t  addr;
        logic        we;
        logic [15:0] din;
        logic [1:0]  mask;      // Active low byte enables
        logic        spare;
    } bank_req_t;

    typedef struct packed {
        logic        done;      // One cycle pulse
        logic [31:0] data;      // First word in the low half
    } bank_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } arb_state_t;

endpackage

`default_nettype wire

//--- src/slot_cache.sv
// ========================================
// One requester slot of the SDRAM bank
// Maps the address into the bank and keeps
// the last word fetched as a one-entry cache
// ========================================
`timescale 1ns/1ns
`default_nettype none

module slot_cache #(
    parameter type data_t = logic [15:0],
    parameter sdram_bank_pkg::slot_id_t SLOT = sdram_bank_pkg::SLOT_RAM
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cs,
    input  logic [22:0]               addr,     // In data_t units
    input  logic                      we,
    input  logic [15:0]               din,
    input  logic [1:0]                mask,
    input  logic                      grant,
    input  sdram_bank_pkg::bank_rsp_t rsp,
    output sdram_bank_pkg::bank_req_t req,
    output logic                      ok,
    output data_t                     dout
);
    import sdram_bank_pkg::*;

    bank_addr_t  word_addr;
    logic [31:0] fetched;
    logic [22:0] last_addr;
    data_t       last_data;
    logic        valid;
    logic        wr_done;
    logic        ok_r;
    logic        same_addr;
    logic        hit;
    logic        done_g;

    assign same_addr = addr == last_addr;
    assign hit       = valid && same_addr;
    assign done_g    = grant && rsp.done;     // Response belongs to this slot

    // Scale to 16-bit SDRAM words
    always_comb begin
        case ($bits(data_t))
            8:       word_addr = {1'b0, addr[22:1]};
            32:      word_addr = {addr[21:0], 1'b0};
            default: word_addr = addr;
        endcase
    end

    always_comb begin
        case ($bits(data_t))
            8:       fetched = {24'd0, addr[0] ? rsp.data[15:8] : rsp.data[7:0]};
            16:      fetched = {16'd0, rsp.data[15:0]};
            default: fetched = rsp.data;
        endcase
    end

    always_comb begin
        req.pending = cs && (we ? !(wr_done && same_addr) : !hit);
        req.addr    = word_addr + SLOT_OFFSET[SLOT];
        req.we      = we;
        req.din     = din;
        req.mask    = mask;
        req.spare   = 1'b0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 1'b0;
            wr_done <= 1'b0;
            ok_r    <= 1'b0;
        end else if (done_g) begin
            valid   <= !we;     // A write drops the cached word
            wr_done <= we;
            ok_r    <= 1'b1;
        end else begin
            wr_done <= wr_done && cs && same_addr;
            ok_r    <= cs && (we ? wr_done && same_addr : hit);
        end
    end

    always_ff @(posedge clk) begin
        if (done_g) begin
            last_addr <= addr;
            if (!we) last_data <= data_t'(fetched[$bits(data_t)-1:0]);
        end
    end

    assign ok   = cs && ok_r && same_addr;
    assign dout = last_data;

endmodule

`default_nettype wire

//--- tb.f
src/sdram_bank_pkg.sv
src/slot_cache.sv
src/burst_counter.sv
src/bank_arbiter.sv
src/sdram_bank.sv
verif/sdram_bank_assertions.sv
verif/sdram_bank_tb.sv

//--- verif/sdram_bank_assertions.sv
// ========================================
// Bank port and slot output assertions
// Bound into the SDRAM bank top level
// ========================================
`timescale 1ns/1ns
`default_nettype none

module sdram_bank_assertions (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       ba_rd,
    input logic                       ba_wr,
    input logic                       ba_ack,
    input sdram_bank_pkg::bank_addr_t ba_addr,
    input logic                       ram_wr_req,
    input logic [3:0]                 cs_vec,
    input logic [3:0]                 ok_vec,
    input logic [3:0]                 grant
);
    // Writes only come from the RAM slot
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(ba_rd && ba_wr) && !(ba_wr && !ram_wr_req))
        else $error("ba_rd and ba_wr high together, or ba_wr without a RAM write request");

    // Request levels wait for ack with the address frozen
    a_rd_held: assert property (@(posedge clk) disable iff (!arst_n)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr))
        else $error("ba_rd or ba_addr changed before ba_ack");

    a_wr_held: assert property (@(posedge clk) disable iff (!arst_n)
        ba_wr && !ba_ack |=> ba_wr && $stable(ba_addr))
        else $error("ba_wr or ba_addr changed before ba_ack");

    a_ok_needs_cs: assert property (@(posedge clk) disable iff (!arst_n)
        (ok_vec & ~(cs_vec & $past(cs_vec))) == 4'd0)    // ok comes an edge after cs
        else $error("ok high while cs is low or cs just rose");

    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && (grant & ~cs_vec) == 4'd0)
        else $error("more than one grant bit set, or grant to a slot without cs");

endmodule

bind sdram_bank sdram_bank_assertions u_assertions (
    .clk        ( clk                              ),
    .arst_n     ( arst_n                           ),
    .ba_rd      ( ba_rd                            ),
    .ba_wr      ( ba_wr                            ),
    .ba_ack     ( ba_ack                           ),
    .ba_addr    ( ba_addr                          ),
    .ram_wr_req ( ram_cs && !ram_rnw               ),
    .cs_vec     ( {gfx_cs, snd_cs, rom_cs, ram_cs} ),
    .ok_vec     ( {gfx_ok, snd_ok, rom_ok, ram_ok} ),
    .grant      ( grant                            )
);

`default_nettype wire

//--- verif/sdram_bank_tb.sv
// ========================================
// Testbench for the SDRAM bank front end
// Random requesters against a bank model
// with a sparse reference memory
// ========================================
`timescale 1ns/1ns
`default_nettype none

module sdram_bank_tb;
    import sdram_bank_pkg::*;

    localparam int         TIMEOUT  = 200;     // Cycles allowed per wait
    localparam bank_addr_t RAM_BASE = 23'h30_0000;
    localparam bank_addr_t ROM_BASE = 23'h00_0000;
    localparam bank_addr_t SND_BASE = 23'h38_0000;
    localparam bank_addr_t GFX_BASE = 23'h10_0000;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        ram_cs;
    logic        ram_rnw;
    logic [16:0] ram_addr;
    logic [15:0] ram_din;
    logic [1:0]  ram_dsn;
    logic        ram_ok;
    logic [15:0] ram_data;
    logic        rom_cs;
    logic [19:0] rom_addr;
    logic        rom_ok;
    logic [15:0] rom_data;
    logic        snd_cs;
    logic [15:0] snd_addr;
    logic        snd_ok;
    logic [7:0]  snd_data;
    logic        gfx_cs;
    logic [19:0] gfx_addr;
    logic        gfx_ok;
    logic [31:0] gfx_data;
    bank_addr_t  ba_addr;
    logic        ba_rd;
    logic        ba_wr;
    logic [15:0] ba_din;
    logic [1:0]  ba_din_m;
    logic        ba_ack;
    logic        ba_dst;
    logic        ba_rdy;
    logic [15:0] data_read;
    logic [3:0]  ok_vec;

    logic [15:0] mem [bank_addr_t];    // Sparse bank contents
    bank_addr_t  seen [$];             // Bank addresses in issue order
    logic [16:0] last_ram;
    logic [19:0] last_rom;
    logic [15:0] last_snd;
    logic [19:0] last_gfx;

    assign ok_vec = {gfx_ok, snd_ok, rom_ok, ram_ok};

    always #2 clk = ~clk;

    sdram_bank DUT (.*);

    function automatic logic [15:0] mem_word(bank_addr_t a);
        if (!mem.exists(a)) mem[a] = 16'($urandom());    // Filled on first touch
        return mem[a];
    endfunction

    // dsn active low, bit 1 selects the upper byte
    function automatic logic [15:0] merge_bytes(logic [15:0] old, logic [15:0] d,
                                                logic [1:0] dsn);
        return {dsn[1] ? old[15:8] : d[15:8], dsn[0] ? old[7:0] : d[7:0]};
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic hang(string what);
        $display("Timeout: %s", what);
        $display("Simulation failed");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic wait_ok(slot_id_t s, string name);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) hang({name, " slot never raised ok"});
        end while (!ok_vec[s]);
    endtask

    task automatic ram_access(logic rnw, logic [16:0] a, logic [15:0] d, logic [1:0] dsn);
        @(posedge clk);
        ram_cs   <= 1'b1;
        ram_rnw  <= rnw;
        ram_addr <= a;
        ram_din  <= d;
        ram_dsn  <= dsn;
        wait_ok(SLOT_RAM, "RAM");
        ram_cs   <= 1'b0;
        last_ram = a;
    endtask

    task automatic ram_read_check(logic [16:0] a);
        ram_access(1'b1, a, 16'd0, 2'b11);
        check("ram_data", 32'(ram_data), 32'(mem_word(RAM_BASE + 23'(a))));
    endtask

    task automatic rom_read_check(logic [19:0] a);
        @(posedge clk);
        rom_cs   <= 1'b1;
        rom_addr <= a;
        wait_ok(SLOT_ROM, "main ROM");
        rom_cs   <= 1'b0;
        last_rom = a;
        check("rom_data", 32'(rom_data), 32'(mem_word(ROM_BASE + 23'(a))));
    endtask

    task automatic snd_read_check(logic [15:0] a);
        logic [15:0] w;
        @(posedge clk);
        snd_cs   <= 1'b1;
        snd_addr <= a;
        wait_ok(SLOT_SND, "sound ROM");
        snd_cs   <= 1'b0;
        last_snd = a;
        w = mem_word(SND_BASE + 23'(a >> 1));    // Two bytes per bank word
        check("snd_data", 32'(snd_data), 32'(a[0] ? w[15:8] : w[7:0]));
    endtask

    task automatic gfx_read_check(logic [19:0] a);
        bank_addr_t w;
        @(posedge clk);
        gfx_cs   <= 1'b1;
        gfx_addr <= a;
        wait_ok(SLOT_GFX, "graphics ROM");
        gfx_cs   <= 1'b0;
        last_gfx = a;
        w = GFX_BASE + 23'({a, 1'b0});
        check("gfx_data", gfx_data, {mem_word(w + 23'd1), mem_word(w)});
    endtask

    // SDRAM controller, one access at a time
    initial begin : bank_model
        bank_addr_t  a;
        logic        is_wr;
        int unsigned delay;
        forever begin
            @(posedge clk);
            if (ba_rd || ba_wr) begin
                a     = ba_addr;
                is_wr = ba_wr;
                seen.push_back(a);
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                ba_ack <= 1'b1;
                if (is_wr) mem[a] = merge_bytes(mem_word(a), ba_din, ba_din_m);
                @(posedge clk);
                ba_ack <= 1'b0;
                if (is_wr) begin
                    ba_rdy <= 1'b1;         // Write ends without data
                end else begin
                    ba_dst    <= 1'b1;
                    data_read <= mem_word(a);
                    @(posedge clk);
                    ba_dst    <= 1'b0;
                    ba_rdy    <= 1'b1;
                    data_read <= mem_word(a + 23'd1);
                end
                @(posedge clk);
                ba_rdy <= 1'b0;
            end
        end
    end

    initial begin : main
        logic [16:0] a;
        logic [15:0] d;
        logic [1:0]  dsn;
        logic [15:0] merged;
        logic [19:0] ro;
        logic [15:0] sa;
        logic [19:0] ga;
        int          n;
        void'($urandom(54161));
        arst_n    = 1'b0;
        ram_cs    = 1'b0;
        ram_rnw   = 1'b1;
        ram_addr  = '0;
        ram_din   = '0;
        ram_dsn   = 2'b11;
        rom_cs    = 1'b0;
        rom_addr  = '0;
        snd_cs    = 1'b0;
        snd_addr  = '0;
        gfx_cs    = 1'b0;
        gfx_addr  = '0;
        ba_ack    = 1'b0;
        ba_dst    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Quiet bank before any request
        repeat (5) begin
            @(posedge clk);
            check("ba_rd", 32'(ba_rd), 32'd0);
            check("ba_wr", 32'(ba_wr), 32'd0);
            check("ok", 32'(ok_vec), 32'd0);
        end

        repeat (24) begin
            ram_read_check(17'($urandom()));
            rom_read_check(20'($urandom()));
            snd_read_check(16'($urandom()));
            gfx_read_check(20'($urandom()));
        end

        // Same addresses again, served from the slots
        n = seen.size();
        ram_read_check(last_ram);
        rom_read_check(last_rom);
        snd_read_check(last_snd);
        gfx_read_check(last_gfx);
        check("bank accesses", 32'(seen.size()), 32'(n));

        repeat (24) begin
            a      = 17'($urandom());
            d      = 16'($urandom());
            dsn    = 2'($urandom());
            merged = merge_bytes(mem_word(RAM_BASE + 23'(a)), d, dsn);
            ram_access(1'b0, a, d, dsn);
            ram_access(1'b1, a, 16'd0, 2'b11);
            check("ram_data", 32'(ram_data), 32'(merged));
        end

        // All four slots at once, fresh addresses so each one misses
        repeat (16) begin
            a  = 17'($urandom());
            ro = 20'($urandom());
            sa = 16'($urandom());
            ga = 20'($urandom());
            if (a == last_ram) a = a ^ 17'd1;
            if (ro == last_rom) ro = ro ^ 20'd1;
            if (sa == last_snd) sa = sa ^ 16'd1;
            if (ga == last_gfx) ga = ga ^ 20'd1;
            seen.delete();
            fork
                ram_read_check(a);
                rom_read_check(ro);
                snd_read_check(sa);
                gfx_read_check(ga);
            join
            check("bank access count", 32'(seen.size()), 32'd4);
            check("ba_addr ram", 32'(seen[0]), 32'(RAM_BASE + 23'(a)));
            check("ba_addr rom", 32'(seen[1]), 32'(ROM_BASE + 23'(ro)));
            check("ba_addr snd", 32'(seen[2]), 32'(SND_BASE + 23'(sa >> 1)));
            check("ba_addr gfx", 32'(seen[3]), 32'(GFX_BASE + 23'({ga, 1'b0})));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
